// ==== dmem_pkg.sv ====
// Shared widths, encodings, region map and access checks of the data memory path
// Imported by every RTL stage and by the testbench reference model
package dmem_pkg;

  localparam int XLEN        = 32;
  localparam int QUEUE_DEPTH = 2;
  localparam int QUEUE_PTR_W = $clog2(QUEUE_DEPTH);
  localparam int QUEUE_CNT_W = $clog2(QUEUE_DEPTH + 1);

  typedef logic [XLEN-1:0] dmem_adr_t;
  typedef logic [XLEN-1:0] dmem_data_t;

  typedef enum logic [1:0] {
    SIZE_BYTE = 2'b00,
    SIZE_HALF = 2'b01,
    SIZE_WORD = 2'b10
  } dmem_size_t;

  // Same encoding as the mstatus privilege field
  typedef enum logic [1:0] {
    PRV_U = 2'b00,
    PRV_M = 2'b11
  } dmem_prv_t;

  typedef enum logic [1:0] {
    FAULT_NONE       = 2'b00,
    FAULT_MISALIGNED = 2'b01,
    FAULT_ACCESS     = 2'b10
  } dmem_fault_t;

  ////////////////////////////////////////////////////////////////////////////
  // Fixed physical memory map
  ////////////////////////////////////////////////////////////////////////////
  localparam dmem_adr_t MEM_BASE  = 32'h0000_0000;
  localparam dmem_adr_t MEM_LAST  = 32'h0FFF_FFFF;
  localparam dmem_adr_t USER_BASE = 32'h0800_0000;
  localparam dmem_adr_t IO_BASE   = 32'h1000_0000;
  localparam dmem_adr_t IO_LAST   = 32'h1000_FFFF;

  function automatic logic in_region(dmem_adr_t adr, dmem_adr_t base, dmem_adr_t last);
    return (adr >= base) && (adr <= last);
  endfunction

  function automatic logic is_misaligned(dmem_adr_t adr, dmem_size_t size);
    case (size)
      SIZE_HALF: return adr[0];
      SIZE_WORD: return |adr[1:0];
      default:   return 1'b0;
    endcase
  endfunction

  function automatic logic is_access_fault(dmem_adr_t adr, dmem_size_t size,
                                           logic we, dmem_prv_t prv);
    logic in_mem;
    logic in_io;
    in_mem = in_region(adr, MEM_BASE, MEM_LAST);
    in_io  = in_region(adr, IO_BASE, IO_LAST);
    // Unmapped space faults on any access
    return !(in_mem || in_io)
        || (in_io && (size != SIZE_WORD))
        || (in_mem && (prv == PRV_U) && (adr < USER_BASE));
  endfunction

endpackage

// ==== dmem_req_queue.sv ====
// Two-entry request queue at the CPU side of the data memory path
// Tags each request with its misaligned flag on the way in
module dmem_req_queue (
  input  logic                 clk_i,
  input  logic                 rst_n_i,
  input  logic                 req_i,
  input  dmem_pkg::dmem_adr_t  adr_i,
  input  dmem_pkg::dmem_size_t size_i,
  input  logic                 we_i,
  input  dmem_pkg::dmem_data_t d_i,
  input  dmem_pkg::dmem_prv_t  prv_i,
  input  logic                 take_i,
  output logic                 valid_o,
  output dmem_pkg::dmem_adr_t  adr_o,
  output dmem_pkg::dmem_size_t size_o,
  output logic                 we_o,
  output dmem_pkg::dmem_data_t d_o,
  output dmem_pkg::dmem_prv_t  prv_o,
  output logic                 misaligned_o,
  output logic                 full_o
);
  import dmem_pkg::*;

  dmem_adr_t              adr_q  [QUEUE_DEPTH];
  dmem_size_t             size_q [QUEUE_DEPTH];
  logic                   we_q   [QUEUE_DEPTH];
  dmem_data_t             d_q    [QUEUE_DEPTH];
  dmem_prv_t              prv_q  [QUEUE_DEPTH];
  logic                   mis_q  [QUEUE_DEPTH];
  logic [QUEUE_PTR_W-1:0] wr_ptr;
  logic [QUEUE_PTR_W-1:0] rd_ptr;
  logic [QUEUE_CNT_W-1:0] count;
  logic                   push;
  logic                   pop;

  function automatic logic [QUEUE_PTR_W-1:0] next_ptr(logic [QUEUE_PTR_W-1:0] ptr);
    return (ptr == QUEUE_PTR_W'(QUEUE_DEPTH - 1)) ? '0 : ptr + 1'b1;
  endfunction

  assign full_o  = (count == QUEUE_CNT_W'(QUEUE_DEPTH));
  assign valid_o = (count != '0);
  assign pop     = take_i & valid_o;
  // A request on a full queue is dropped unless the head leaves now
  assign push    = req_i & (~full_o | pop);

  always_ff @(posedge clk_i)
  begin
    if (!rst_n_i)
    begin
      wr_ptr <= '0;
      rd_ptr <= '0;
      count  <= '0;
    end
    else
    begin
      if (push) wr_ptr <= next_ptr(wr_ptr);
      if (pop)  rd_ptr <= next_ptr(rd_ptr);
      count <= count + QUEUE_CNT_W'(push) - QUEUE_CNT_W'(pop);
    end
  end

  // Entry storage
  always_ff @(posedge clk_i)
  begin
    if (push)
    begin
      adr_q[wr_ptr]  <= adr_i;
      size_q[wr_ptr] <= size_i;
      we_q[wr_ptr]   <= we_i;
      d_q[wr_ptr]    <= d_i;
      prv_q[wr_ptr]  <= prv_i;
      mis_q[wr_ptr]  <= is_misaligned(adr_i, size_i);
    end
  end

  assign adr_o        = adr_q[rd_ptr];
  assign size_o       = size_q[rd_ptr];
  assign we_o         = we_q[rd_ptr];
  assign d_o          = d_q[rd_ptr];
  assign prv_o        = prv_q[rd_ptr];
  assign misaligned_o = mis_q[rd_ptr];

  // CPU must respect the full level
  a_no_overflow: assert property (@(posedge clk_i) disable iff (!rst_n_i)
    req_i && full_o |-> pop)
    else $error("request issued while queue full");

endmodule

// ==== dmem_attr_chk.sv ====
// Attribute stage, classifies the queue head against the fixed region rules
// Holds one item and forwards it with its fault class to the bus controller
module dmem_attr_chk (
  input  logic                  clk_i,
  input  logic                  rst_n_i,
  input  logic                  valid_i,
  input  dmem_pkg::dmem_adr_t   adr_i,
  input  dmem_pkg::dmem_size_t  size_i,
  input  logic                  we_i,
  input  dmem_pkg::dmem_data_t  d_i,
  input  dmem_pkg::dmem_prv_t   prv_i,
  input  logic                  misaligned_i,
  input  logic                  take_i,
  output logic                  take_o,
  output logic                  valid_o,
  output dmem_pkg::dmem_adr_t   adr_o,
  output dmem_pkg::dmem_size_t  size_o,
  output logic                  we_o,
  output dmem_pkg::dmem_data_t  d_o,
  output dmem_pkg::dmem_prv_t   prv_o,
  output dmem_pkg::dmem_fault_t fault_o
);
  import dmem_pkg::*;

  logic        valid_q;
  dmem_fault_t fault_d;

  // Room when empty or when the current item leaves this cycle
  assign take_o  = ~valid_q | take_i;
  assign valid_o = valid_q;

  // Misaligned wins over an access fault
  always_comb
  begin
    if (misaligned_i)
      fault_d = FAULT_MISALIGNED;
    else if (is_access_fault(adr_i, size_i, we_i, prv_i))
      fault_d = FAULT_ACCESS;
    else
      fault_d = FAULT_NONE;
  end

  always_ff @(posedge clk_i)
  begin
    if (!rst_n_i)
      valid_q <= 1'b0;
    else if (take_o)
      valid_q <= valid_i;
  end

  // Item register
  always_ff @(posedge clk_i)
  begin
    if (valid_i && take_o)
    begin
      adr_o   <= adr_i;
      size_o  <= size_i;
      we_o    <= we_i;
      d_o     <= d_i;
      prv_o   <= prv_i;
      fault_o <= fault_d;
    end
  end

  // Stalled item must not change under the bus controller
  a_hold_stable: assert property (@(posedge clk_i) disable iff (!rst_n_i)
    valid_o && !take_i |=> valid_o && $stable({adr_o, size_o, we_o, d_o, prv_o, fault_o}))
    else $error("attribute stage item changed while stalled");

endmodule

// ==== dmem_bus_ctrl.sv ====
// Bus side of the data memory path, one strobed transfer per legal request
// Turns faults and bus completions into a single CPU response pulse
module dmem_bus_ctrl (
  input  logic                  clk_i,
  input  logic                  rst_n_i,
  input  logic                  valid_i,
  input  dmem_pkg::dmem_adr_t   adr_i,
  input  dmem_pkg::dmem_size_t  size_i,
  input  logic                  we_i,
  input  dmem_pkg::dmem_data_t  d_i,
  input  dmem_pkg::dmem_prv_t   prv_i,
  input  dmem_pkg::dmem_fault_t fault_i,
  input  dmem_pkg::dmem_data_t  bus_q_i,
  input  logic                  bus_ack_i,
  input  logic                  bus_err_i,
  output logic                  take_o,
  output logic                  bus_stb_o,
  output dmem_pkg::dmem_adr_t   bus_adr_o,
  output dmem_pkg::dmem_size_t  bus_size_o,
  output logic                  bus_we_o,
  output dmem_pkg::dmem_prv_t   bus_prv_o,
  output dmem_pkg::dmem_data_t  bus_d_o,
  output dmem_pkg::dmem_data_t  mem_q_o,
  output logic                  mem_ack_o,
  output logic                  mem_err_o,
  output logic                  mem_misaligned_o
);
  import dmem_pkg::*;

  typedef enum logic [1:0] {
    ST_IDLE,
    ST_ACCESS,
    ST_RESPOND
  } state_t;

  state_t      state;
  dmem_fault_t resp_q;
  logic        take;
  logic        bus_done;

  assign take_o   = (state == ST_IDLE);
  assign take     = valid_i & take_o;
  assign bus_done = bus_stb_o & (bus_ack_i | bus_err_i);

  ////////////////////////////////////////////////////////////////////////////
  // FSM
  ////////////////////////////////////////////////////////////////////////////
  always_ff @(posedge clk_i)
  begin
    if (!rst_n_i)
      state <= ST_IDLE;
    else
    begin
      case (state)
        ST_IDLE:
          if (take)
            state <= (fault_i == FAULT_NONE) ? ST_ACCESS : ST_RESPOND;
        ST_ACCESS:
          if (bus_ack_i || bus_err_i) state <= ST_RESPOND;
        default:
          state <= ST_IDLE;
      endcase
    end
  end

  // Transfer payload and response kind
  always_ff @(posedge clk_i)
  begin
    if (take)
    begin
      bus_adr_o  <= adr_i;
      bus_size_o <= size_i;
      bus_we_o   <= we_i;
      bus_prv_o  <= prv_i;
      bus_d_o    <= d_i;
      resp_q     <= fault_i;
    end
    if (bus_done)
    begin
      mem_q_o <= bus_q_i;
      // error wins if the slave raises both
      resp_q  <= bus_err_i ? FAULT_ACCESS : FAULT_NONE;
    end
  end

  ////////////////////////////////////////////////////////////////////////////
  // Outputs
  ////////////////////////////////////////////////////////////////////////////
  assign bus_stb_o        = (state == ST_ACCESS);
  assign mem_ack_o        = (state == ST_RESPOND) && (resp_q == FAULT_NONE);
  assign mem_err_o        = (state == ST_RESPOND) && (resp_q == FAULT_ACCESS);
  assign mem_misaligned_o = (state == ST_RESPOND) && (resp_q == FAULT_MISALIGNED);

  a_one_response: assert property (@(posedge clk_i) disable iff (!rst_n_i)
    $onehot0({mem_ack_o, mem_err_o, mem_misaligned_o}))
    else $error("more than one response pulse");

  // Strobe and payload hold until the slave completes
  a_bus_stable: assert property (@(posedge clk_i) disable iff (!rst_n_i)
    bus_stb_o && !bus_ack_i && !bus_err_i |=>
      bus_stb_o && $stable({bus_adr_o, bus_size_o, bus_we_o, bus_prv_o, bus_d_o}))
    else $error("bus transfer changed before completion");

endmodule

// ==== dmem_ctrl.sv ====
// Data memory access path of the core without cache or MMU
// Chains request queue, attribute check and bus controller
module dmem_ctrl (
  input  logic                 clk_i,
  input  logic                 rst_n_i,

  // CPU side
  input  logic                 mem_req_i,
  input  dmem_pkg::dmem_adr_t  mem_adr_i,
  input  dmem_pkg::dmem_size_t mem_size_i,
  input  logic                 mem_we_i,
  input  dmem_pkg::dmem_data_t mem_d_i,
  input  dmem_pkg::dmem_prv_t  st_prv_i,
  output logic                 mem_full_o,
  output dmem_pkg::dmem_data_t mem_q_o,
  output logic                 mem_ack_o,
  output logic                 mem_err_o,
  output logic                 mem_misaligned_o,

  // Bus side
  output logic                 bus_stb_o,
  output dmem_pkg::dmem_adr_t  bus_adr_o,
  output dmem_pkg::dmem_size_t bus_size_o,
  output logic                 bus_we_o,
  output dmem_pkg::dmem_prv_t  bus_prv_o,
  output dmem_pkg::dmem_data_t bus_d_o,
  input  dmem_pkg::dmem_data_t bus_q_i,
  input  logic                 bus_ack_i,
  input  logic                 bus_err_i
);
  import dmem_pkg::*;

  // Queue head
  logic        q_valid;
  dmem_adr_t   q_adr;
  dmem_size_t  q_size;
  logic        q_we;
  dmem_data_t  q_d;
  dmem_prv_t   q_prv;
  logic        q_misaligned;
  logic        chk_take;

  // Classified item
  logic        c_valid;
  dmem_adr_t   c_adr;
  dmem_size_t  c_size;
  logic        c_we;
  dmem_data_t  c_d;
  dmem_prv_t   c_prv;
  dmem_fault_t c_fault;
  logic        bus_take;

  dmem_req_queue u_req_queue (
    .clk_i        ( clk_i        ),
    .rst_n_i      ( rst_n_i      ),
    .req_i        ( mem_req_i    ),
    .adr_i        ( mem_adr_i    ),
    .size_i       ( mem_size_i   ),
    .we_i         ( mem_we_i     ),
    .d_i          ( mem_d_i      ),
    .prv_i        ( st_prv_i     ),
    .take_i       ( chk_take     ),
    .valid_o      ( q_valid      ),
    .adr_o        ( q_adr        ),
    .size_o       ( q_size       ),
    .we_o         ( q_we         ),
    .d_o          ( q_d          ),
    .prv_o        ( q_prv        ),
    .misaligned_o ( q_misaligned ),
    .full_o       ( mem_full_o   )
  );

  dmem_attr_chk u_attr_chk (
    .clk_i        ( clk_i        ),
    .rst_n_i      ( rst_n_i      ),
    .valid_i      ( q_valid      ),
    .adr_i        ( q_adr        ),
    .size_i       ( q_size       ),
    .we_i         ( q_we         ),
    .d_i          ( q_d          ),
    .prv_i        ( q_prv        ),
    .misaligned_i ( q_misaligned ),
    .take_i       ( bus_take     ),
    .take_o       ( chk_take     ),
    .valid_o      ( c_valid      ),
    .adr_o        ( c_adr        ),
    .size_o       ( c_size       ),
    .we_o         ( c_we         ),
    .d_o          ( c_d          ),
    .prv_o        ( c_prv        ),
    .fault_o      ( c_fault      )
  );

  dmem_bus_ctrl u_bus_ctrl (
    .clk_i            ( clk_i            ),
    .rst_n_i          ( rst_n_i          ),
    .valid_i          ( c_valid          ),
    .adr_i            ( c_adr            ),
    .size_i           ( c_size           ),
    .we_i             ( c_we             ),
    .d_i              ( c_d              ),
    .prv_i            ( c_prv            ),
    .fault_i          ( c_fault          ),
    .bus_q_i          ( bus_q_i          ),
    .bus_ack_i        ( bus_ack_i        ),
    .bus_err_i        ( bus_err_i        ),
    .take_o           ( bus_take         ),
    .bus_stb_o        ( bus_stb_o        ),
    .bus_adr_o        ( bus_adr_o        ),
    .bus_size_o       ( bus_size_o       ),
    .bus_we_o         ( bus_we_o         ),
    .bus_prv_o        ( bus_prv_o        ),
    .bus_d_o          ( bus_d_o          ),
    .mem_q_o          ( mem_q_o          ),
    .mem_ack_o        ( mem_ack_o        ),
    .mem_err_o        ( mem_err_o        ),
    .mem_misaligned_o ( mem_misaligned_o )
  );

endmodule

// ==== tb_bus_model.sv ====
// Bus slave for the data memory testbench, 256-word memory with random wait states
// Flags an error for I/O addresses with bit 15 set
module tb_bus_model #(
  parameter logic [31:0] SEED = 32'h1
) (
  input  logic                 clk_i,
  input  logic                 rst_n_i,
  input  logic                 stb_i,
  input  dmem_pkg::dmem_adr_t  adr_i,
  input  logic                 we_i,
  input  dmem_pkg::dmem_data_t d_i,
  output dmem_pkg::dmem_data_t q_o,
  output logic                 ack_o,
  output logic                 err_o
);
  import dmem_pkg::*;

  dmem_data_t  mem [256];
  logic [31:0] rng;
  logic [1:0]  wait_cnt;
  logic        busy;

  function automatic logic [31:0] step_xorshift(logic [31:0] x);
    x = x ^ (x << 13);
    x = x ^ (x >> 17);
    x = x ^ (x << 5);
    return x;
  endfunction

  always_ff @(posedge clk_i)
  begin
    if (!rst_n_i)
    begin
      ack_o    <= 1'b0;
      err_o    <= 1'b0;
      busy     <= 1'b0;
      wait_cnt <= '0;
      q_o      <= '0;
      rng      <= SEED;
      for (int i = 0; i < 256; i++)
        mem[i] <= '0;
    end
    else
    begin
      ack_o <= 1'b0;
      err_o <= 1'b0;
      if (stb_i && !ack_o && !err_o)
      begin
        if (!busy)
        begin
          // New transfer, pick 0 to 2 extra wait states
          busy     <= 1'b1;
          rng      <= step_xorshift(rng);
          wait_cnt <= 2'(rng % 32'd3);
        end
        else if (wait_cnt != 2'd0)
          wait_cnt <= wait_cnt - 2'd1;
        else
        begin
          busy <= 1'b0;
          if ((adr_i[31:16] == IO_BASE[31:16]) && adr_i[15])
            err_o <= 1'b1;
          else
          begin
            ack_o <= 1'b1;
            q_o   <= mem[adr_i[9:2]];
            if (we_i)
              mem[adr_i[9:2]] <= d_i;
          end
        end
      end
    end
  end

endmodule

// ==== tb_dmem_ctrl.sv ====
// Testbench for the data memory path, random requests checked against a reference queue
// Runs the directed groups in sequence and prints one line per group
module tb_dmem_ctrl;
  import dmem_pkg::*;

  localparam int N_REQ          = 4 + 16 + 12 + 12 + 6 + 40;
  localparam int TIMEOUT_CYCLES = 8 * N_REQ + 100;

  logic       clk = 1'b0;
  logic       rst_n;
  logic       mem_req;
  dmem_adr_t  mem_adr;
  dmem_size_t mem_size;
  logic       mem_we;
  dmem_data_t mem_d;
  dmem_prv_t  st_prv;
  logic       mem_full;
  dmem_data_t mem_q;
  logic       mem_ack;
  logic       mem_err;
  logic       mem_misaligned;
  logic       bus_stb;
  dmem_adr_t  bus_adr;
  dmem_size_t bus_size;
  logic       bus_we;
  dmem_prv_t  bus_prv;
  dmem_data_t bus_d;
  dmem_data_t bus_q;
  logic       bus_ack;
  logic       bus_err;

  // Reference state
  dmem_fault_t exp_kind[$];
  logic        exp_read[$];
  dmem_data_t  exp_data[$];
  dmem_adr_t   exp_bus_adr[$];
  dmem_size_t  exp_bus_size[$];
  logic        exp_bus_we[$];
  dmem_prv_t   exp_bus_prv[$];
  dmem_data_t  exp_bus_d[$];
  dmem_data_t  shadow [256];
  logic [31:0] rng_state = 32'hbcf5c593;
  logic        full_seen = 1'b0;
  int          cycles = 0;
  int          errors = 0;
  int          errors_at_start = 0;
  int          checks = 0;
  int          tests = 0;
  int          responses = 0;

  dmem_ctrl u_dmem_ctrl (
    .clk_i            ( clk            ),
    .rst_n_i          ( rst_n          ),
    .mem_req_i        ( mem_req        ),
    .mem_adr_i        ( mem_adr        ),
    .mem_size_i       ( mem_size       ),
    .mem_we_i         ( mem_we         ),
    .mem_d_i          ( mem_d          ),
    .st_prv_i         ( st_prv         ),
    .mem_full_o       ( mem_full       ),
    .mem_q_o          ( mem_q          ),
    .mem_ack_o        ( mem_ack        ),
    .mem_err_o        ( mem_err        ),
    .mem_misaligned_o ( mem_misaligned ),
    .bus_stb_o        ( bus_stb        ),
    .bus_adr_o        ( bus_adr        ),
    .bus_size_o       ( bus_size       ),
    .bus_we_o         ( bus_we         ),
    .bus_prv_o        ( bus_prv        ),
    .bus_d_o          ( bus_d          ),
    .bus_q_i          ( bus_q          ),
    .bus_ack_i        ( bus_ack        ),
    .bus_err_i        ( bus_err        )
  );

  tb_bus_model #(
    .SEED ( 32'hbcf5c593 )
  ) u_bus_model (
    .clk_i   ( clk     ),
    .rst_n_i ( rst_n   ),
    .stb_i   ( bus_stb ),
    .adr_i   ( bus_adr ),
    .we_i    ( bus_we  ),
    .d_i     ( bus_d   ),
    .q_o     ( bus_q   ),
    .ack_o   ( bus_ack ),
    .err_o   ( bus_err )
  );

  always #2 clk = ~clk;

  always @(posedge clk)
  begin
    cycles <= cycles + 1;
    if (cycles >= TIMEOUT_CYCLES)
    begin
      $display("timeout after %0d cycles, %0d responses missing", cycles, exp_kind.size());
      $display("** FAIL **");
      $finish;
    end
  end

  ////////////////////////////////////////////////////////////////////////////
  // Reference model
  ////////////////////////////////////////////////////////////////////////////
  function automatic logic [31:0] xorshift32(logic [31:0] x);
    x = x ^ (x << 13);
    x = x ^ (x >> 17);
    x = x ^ (x << 5);
    return x;
  endfunction

  function automatic logic [31:0] rand32();
    rng_state = xorshift32(rng_state);
    return rng_state;
  endfunction

  function automatic dmem_size_t random_size(logic [1:0] sel);
    case (sel)
      2'd0:    return SIZE_BYTE;
      2'd1:    return SIZE_HALF;
      default: return SIZE_WORD;
    endcase
  endfunction

  // Region map, alignment and privilege rules
  function automatic dmem_fault_t expected_kind(dmem_adr_t adr, dmem_size_t size,
                                                dmem_prv_t prv);
    logic in_mem;
    logic in_io;
    in_mem = (adr <= MEM_LAST);
    in_io  = (adr >= IO_BASE) && (adr <= IO_LAST);
    if (((size == SIZE_HALF) && adr[0]) || ((size == SIZE_WORD) && (adr[1:0] != 2'b00)))
      return FAULT_MISALIGNED;
    if (!in_mem && !in_io)
      return FAULT_ACCESS;
    if (in_io && (size != SIZE_WORD))
      return FAULT_ACCESS;
    if (in_mem && (prv == PRV_U) && (adr < USER_BASE))
      return FAULT_ACCESS;
    return FAULT_NONE;
  endfunction

  ////////////////////////////////////////////////////////////////////////////
  // Compare tasks
  ////////////////////////////////////////////////////////////////////////////
  task automatic check_kind(input string name, input dmem_fault_t got, input dmem_fault_t exp);
    checks++;
    if (got !== exp)
    begin
      errors++;
      $display("FAILED t=%0t %s: got %s expected %s", $time, name, got.name(), exp.name());
    end
  endtask

  task automatic check_data(input string name, input dmem_data_t got, input dmem_data_t exp);
    checks++;
    if (got !== exp)
    begin
      errors++;
      $display("FAILED t=%0t %s: got %h expected %h", $time, name, got, exp);
    end
  endtask

  task automatic check_adr(input string name, input dmem_adr_t got, input dmem_adr_t exp);
    checks++;
    if (got !== exp)
    begin
      errors++;
      $display("FAILED t=%0t %s: got %h expected %h", $time, name, got, exp);
    end
  endtask

  task automatic check_size(input string name, input dmem_size_t got, input dmem_size_t exp);
    checks++;
    if (got !== exp)
    begin
      errors++;
      $display("FAILED t=%0t %s: got %s expected %s", $time, name, got.name(), exp.name());
    end
  endtask

  task automatic check_prv(input string name, input dmem_prv_t got, input dmem_prv_t exp);
    checks++;
    if (got !== exp)
    begin
      errors++;
      $display("FAILED t=%0t %s: got %s expected %s", $time, name, got.name(), exp.name());
    end
  endtask

  task automatic check_bit(input string name, input logic got, input logic exp);
    checks++;
    if (got !== exp)
    begin
      errors++;
      $display("FAILED t=%0t %s: got %b expected %b", $time, name, got, exp);
    end
  endtask

  ////////////////////////////////////////////////////////////////////////////
  // Stimulus and response monitor
  ////////////////////////////////////////////////////////////////////////////
  task automatic send(input dmem_adr_t adr, input dmem_size_t size, input logic we,
                      input dmem_data_t d, input dmem_prv_t prv);
    dmem_fault_t kind;
    logic        bus_error;
    logic        done_ok;
    kind      = expected_kind(adr, size, prv);
    bus_error = (kind == FAULT_NONE) && (adr[31:16] == IO_BASE[31:16]) && adr[15];
    done_ok   = (kind == FAULT_NONE) && !bus_error;
    @(negedge clk);
    while (mem_full)
      @(negedge clk);
    @(posedge clk);
    mem_req  <= 1'b1;
    mem_adr  <= adr;
    mem_size <= size;
    mem_we   <= we;
    mem_d    <= d;
    st_prv   <= prv;
    if (kind == FAULT_NONE)
    begin
      exp_bus_adr.push_back(adr);
      exp_bus_size.push_back(size);
      exp_bus_we.push_back(we);
      exp_bus_prv.push_back(prv);
      exp_bus_d.push_back(d);
    end
    exp_kind.push_back(bus_error ? FAULT_ACCESS : kind);
    exp_read.push_back(done_ok && !we);
    exp_data.push_back(shadow[adr[9:2]]);
    // Slave writes the whole word whatever the size
    if (done_ok && we)
      shadow[adr[9:2]] = d;
    @(posedge clk);
    mem_req <= 1'b0;
  endtask

  // Completing bus transfer against the oldest legal request
  task automatic check_transfer();
    logic       we;
    dmem_data_t d;
    check_adr("bus_adr_o", bus_adr, exp_bus_adr.pop_front());
    check_size("bus_size_o", bus_size, exp_bus_size.pop_front());
    check_prv("bus_prv_o", bus_prv, exp_bus_prv.pop_front());
    we = exp_bus_we.pop_front();
    d  = exp_bus_d.pop_front();
    check_bit("bus_we_o", bus_we, we);
    if (we)
      check_data("bus_d_o", bus_d, d);
  endtask

  task automatic take_response();
    dmem_fault_t got;
    logic        is_read;
    dmem_data_t  data;
    if (mem_ack)
      got = FAULT_NONE;
    else if (mem_err)
      got = FAULT_ACCESS;
    else
      got = FAULT_MISALIGNED;
    if ($countones({mem_ack, mem_err, mem_misaligned}) > 1)
    begin
      errors++;
      $display("more than one response pulse at t=%0t", $time);
    end
    if (exp_kind.size() == 0)
    begin
      errors++;
      $display("response at t=%0t with no request outstanding", $time);
    end
    else
    begin
      check_kind("response", got, exp_kind.pop_front());
      is_read = exp_read.pop_front();
      data    = exp_data.pop_front();
      if (is_read && (got == FAULT_NONE))
        check_data("mem_q_o", mem_q, data);
      responses++;
    end
  endtask

  always @(negedge clk)
  begin
    if (rst_n)
    begin
      if (mem_full)
        full_seen = 1'b1;
      if (bus_stb && (exp_bus_adr.size() == 0))
      begin
        errors++;
        $display("bus strobe at t=%0t with no legal request outstanding", $time);
      end
      else if (bus_stb && (bus_ack || bus_err))
        check_transfer();
      if (mem_ack || mem_err || mem_misaligned)
        take_response();
    end
  end

  task automatic finish_test(input string name);
    while (exp_kind.size() != 0)
      @(negedge clk);
    tests++;
    if (errors == errors_at_start)
      $display("test %-14s ok", name);
    else
      $display("test %-14s %0d errors", name, errors - errors_at_start);
    errors_at_start = errors;
  endtask

  ////////////////////////////////////////////////////////////////////////////
  // Test groups
  ////////////////////////////////////////////////////////////////////////////
  task automatic test_reset_state();
    @(negedge clk);
    check_bit("mem_ack_o", mem_ack, 1'b0);
    check_bit("mem_err_o", mem_err, 1'b0);
    check_bit("mem_misaligned_o", mem_misaligned, 1'b0);
    check_bit("bus_stb_o", bus_stb, 1'b0);
    check_bit("mem_full_o", mem_full, 1'b0);
    finish_test("reset");
  endtask

  task automatic test_write_read();
    dmem_adr_t adr;
    // Nothing written yet, all reads see zero
    for (int i = 0; i < 4; i++)
      send(USER_BASE | (rand32() & 32'h3FC), SIZE_WORD, 1'b0, '0, PRV_U);
    for (int i = 0; i < 8; i++)
    begin
      adr = USER_BASE | 32'h0100_0000 | (rand32() & 32'h3FC);
      send(adr, SIZE_WORD, 1'b1, rand32(), PRV_U);
      send(adr, SIZE_WORD, 1'b0, '0, PRV_M);
    end
    finish_test("write_read");
  endtask

  task automatic test_misaligned();
    logic [31:0] r;
    dmem_adr_t   adr;
    dmem_size_t  size;
    for (int i = 0; i < 12; i++)
    begin
      r    = rand32();
      adr  = rand32();
      size = r[0] ? SIZE_HALF : SIZE_WORD;
      if (size == SIZE_HALF)
        adr[0] = 1'b1;
      else if (adr[1:0] == 2'b00)
        adr[1:0] = 2'b10;
      send(adr, size, r[1], rand32(), r[2] ? PRV_M : PRV_U);
    end
    finish_test("misaligned");
  endtask

  task automatic test_access_fault();
    logic [31:0] r;
    for (int i = 0; i < 12; i++)
    begin
      r = rand32();
      case (i % 3)
        0:       send(32'h4000_0000 | (r & 32'h3FFF_FFFC), SIZE_WORD, r[31], r, PRV_M);
        1:       send(IO_BASE | (r & 32'h0000_FFFE), r[16] ? SIZE_HALF : SIZE_BYTE, r[31], r,
                      PRV_M);
        default: send(r & 32'h07FF_FFFC, SIZE_WORD, r[31], r, PRV_U);
      endcase
    end
    finish_test("access_fault");
  endtask

  task automatic test_bus_error();
    logic [31:0] r;
    for (int i = 0; i < 6; i++)
    begin
      r = rand32();
      send(IO_BASE | 32'h8000 | (r & 32'h7FFC), SIZE_WORD, r[0], rand32(),
           r[1] ? PRV_M : PRV_U);
    end
    finish_test("bus_error");
  endtask

  task automatic test_ordering();
    logic [31:0] r;
    dmem_adr_t   adr;
    dmem_size_t  size;
    full_seen = 1'b0;
    for (int i = 0; i < 40; i++)
    begin
      r    = rand32();
      adr  = USER_BASE | (r & 32'h0000_03FC);
      size = SIZE_WORD;
      // Mostly legal traffic so the bus stays busy
      case (r[30:28])
        3'd0:    adr = adr | 32'h1;
        3'd1:    adr = adr | 32'h4000_0000;
        3'd2:    adr = IO_BASE | (r & 32'h0000_83FC);
        3'd3:    size = random_size(r[21:20]);
        default: ;
      endcase
      send(adr, size, r[31], rand32(), r[27] ? PRV_M : PRV_U);
    end
    if (!full_seen)
    begin
      errors++;
      $display("queue never reported full under back-to-back requests");
    end
    finish_test("ordering");
  endtask

  initial
  begin
    rst_n    = 1'b0;
    mem_req  = 1'b0;
    mem_adr  = '0;
    mem_size = SIZE_WORD;
    mem_we   = 1'b0;
    mem_d    = '0;
    st_prv   = PRV_M;
    for (int i = 0; i < 256; i++)
      shadow[i] = '0;
    repeat (10) @(posedge clk);
    rst_n <= 1'b1;
    test_reset_state();
    test_write_read();
    test_misaligned();
    test_access_fault();
    test_bus_error();
    test_ordering();
    $display("tests %0d, responses %0d, checks %0d, errors %0d", tests, responses, checks,
             errors);
    if (errors == 0)
      $display("** PASS **");
    else
      $display("** FAIL **");
    $finish;
  end

endmodule

// ==== src.f ====
dmem_pkg.sv
dmem_req_queue.sv
dmem_attr_chk.sv
dmem_bus_ctrl.sv
dmem_ctrl.sv
tb_bus_model.sv
tb_dmem_ctrl.sv

// ==== Makefile ====
# Verilator flow for the data memory path
# Usage: make lint | make sim | make clean

VERILATOR  ?= verilator
TOP        ?= tb_dmem_ctrl
RTL_TOP    ?= dmem_ctrl
FILELIST   ?= src.f
BUILD_DIR  ?= obj_dir
LINT_FLAGS ?= -Wall
SIM_FLAGS  ?= --binary --timing --assert
PASS_MSG   ?= ** PASS **

SIM_BIN  := $(BUILD_DIR)/V$(TOP)
SOURCES  := $(shell cat $(FILELIST))

.PHONY: all lint sim clean

all: sim

lint:
	$(VERILATOR) --lint-only $(LINT_FLAGS) --top-module $(RTL_TOP) -f $(FILELIST)

$(SIM_BIN): $(SOURCES) $(FILELIST)
	$(VERILATOR) $(SIM_FLAGS) --top-module $(TOP) -Mdir $(BUILD_DIR) -f $(FILELIST)

sim: $(SIM_BIN)
	@out="$$(./$(SIM_BIN))"; echo "$$out"; \
	echo "$$out" | grep -qF -- '$(PASS_MSG)'

clean:
	rm -rf $(BUILD_DIR)
